// ==== net_types_pkg.sv ====
`default_nettype none

package net_types_pkg;

    // One byte of the frame stream
    typedef logic [7:0] byte_t;

    // Ethernet station address
    typedef logic [47:0] mac_addr_t;

    // IPv4 address, first octet in the top byte
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length or IP total length
    typedef logic [15:0] len16_t;

    // Ethertype carried in bytes 12 and 13
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

    // IPv4 version 4 with a five word header
    localparam byte_t IP_VER_IHL = 8'h45;

    // Protocol number for UDP
    localparam byte_t IP_PROTO_UDP = 8'd17;

    // Hop limit on every reply
    localparam byte_t IP_TTL_REPLY = 8'd64;

    // IPv4 header without options
    localparam int IP_HDR_BYTES = 20;

    // Ethernet, IPv4 and UDP headers back to back
    localparam int HDR_BYTES = 42;

endpackage

`default_nettype wire

// ==== echo_ctrl_pkg.sv ====
`default_nettype none

package echo_ctrl_pkg;

    // Byte position within the 42 byte header
    typedef logic [5:0] hdr_index_t;

    // Input side
    typedef enum logic [1:0] {
        HEADER,
        WAIT_HDR,
        PAYLOAD,
        DROP
    } parser_state_t;

    // Output side
    typedef enum logic [1:0] {
        IDLE,
        SEND_HDR,
        SEND_PAYLOAD
    } builder_state_t;

endpackage

`default_nettype wire

// ==== frame_header_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_header_parser
    import net_types_pkg::*;
    import echo_ctrl_pkg::*;
#(
    parameter ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter udp_port_t ECHO_PORT = 16'd1234
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,

    input  byte_t     rx_data,
    input  wire logic rx_valid,
    output logic      rx_ready,
    input  wire logic rx_last,

    output logic      hdr_valid,
    input  wire logic hdr_ready,
    output mac_addr_t hdr_dest_mac,
    output ip_addr_t  hdr_dest_ip,
    output udp_port_t hdr_dest_port,
    output len16_t    hdr_udp_length,

    output byte_t     wr_data,
    output logic      wr_last,
    output logic      wr_valid,
    input  wire logic wr_ready
);

    parser_state_t state;
    hdr_index_t    hdr_idx;
    logic          match;
    logic          match_next;
    logic          byte_ok;
    logic          rx_enable;
    logic          rx_take;

    // Input stays blocked for the first cycle out of reset
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            rx_enable <= 1'b0;
        end else begin
            rx_enable <= 1'b1;
        end
    end

    always_comb begin
        case (state)
            HEADER, DROP: rx_ready = rx_enable;
            PAYLOAD:      rx_ready = wr_ready;
            default:      rx_ready = 1'b0;
        endcase
    end

    assign rx_take = rx_valid && rx_ready;

    // Payload goes straight through to the FIFO
    assign wr_data  = rx_data;
    assign wr_last  = rx_last;
    assign wr_valid = rx_valid && (state == PAYLOAD);

    // Compare the fields that decide acceptance as they pass
    always_comb begin
        case (hdr_idx)
            6'd12:   byte_ok = (rx_data == ETH_TYPE_IPV4[15:8]);
            6'd13:   byte_ok = (rx_data == ETH_TYPE_IPV4[7:0]);
            6'd14:   byte_ok = (rx_data == IP_VER_IHL);
            6'd23:   byte_ok = (rx_data == IP_PROTO_UDP);
            6'd30:   byte_ok = (rx_data == LOCAL_IP[31:24]);
            6'd31:   byte_ok = (rx_data == LOCAL_IP[23:16]);
            6'd32:   byte_ok = (rx_data == LOCAL_IP[15:8]);
            6'd33:   byte_ok = (rx_data == LOCAL_IP[7:0]);
            6'd36:   byte_ok = (rx_data == ECHO_PORT[15:8]);
            6'd37:   byte_ok = (rx_data == ECHO_PORT[7:0]);
            default: byte_ok = 1'b1;
        endcase
    end

    assign match_next = ((hdr_idx == '0) || match) && byte_ok;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state     <= HEADER;
            hdr_idx   <= '0;
            match     <= 1'b0;
            hdr_valid <= 1'b0;
        end else begin
            case (state)
                HEADER: begin
                    if (rx_take) begin
                        match <= match_next;
                        if (rx_last) begin
                            // Too short, or a header with nothing behind it
                            hdr_idx <= '0;
                        end else if (hdr_idx == hdr_index_t'(HDR_BYTES - 1)) begin
                            hdr_idx   <= '0;
                            hdr_valid <= match_next;
                            state     <= match_next ? WAIT_HDR : DROP;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                WAIT_HDR: begin
                    if (hdr_ready) begin
                        hdr_valid <= 1'b0;
                        state     <= PAYLOAD;
                    end
                end
                PAYLOAD, DROP: begin
                    if (rx_take && rx_last) begin
                        state <= HEADER;
                    end
                end
                default: state <= HEADER;
            endcase
        end
    end

    // Reply fields shift in only while the header streams in
    always_ff @(posedge clk_125mhz) begin
        if (state == HEADER && rx_take) begin
            if (hdr_idx >= 6'd6 && hdr_idx <= 6'd11) begin
                hdr_dest_mac <= {hdr_dest_mac[39:0], rx_data};
            end
            if (hdr_idx >= 6'd26 && hdr_idx <= 6'd29) begin
                hdr_dest_ip <= {hdr_dest_ip[23:0], rx_data};
            end
            if (hdr_idx == 6'd34 || hdr_idx == 6'd35) begin
                hdr_dest_port <= {hdr_dest_port[7:0], rx_data};
            end
            if (hdr_idx == 6'd38 || hdr_idx == 6'd39) begin
                hdr_udp_length <= {hdr_udp_length[7:0], rx_data};
            end
        end
    end

    // Only payload of an accepted header that was handed over reaches the FIFO
    a_wr_only_in_payload: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        wr_valid |-> match && !hdr_valid
    );

endmodule

`default_nettype wire

// ==== payload_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import net_types_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH = 13
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,

    input  byte_t     wr_data,
    input  wire logic wr_last,
    input  wire logic wr_valid,
    output logic      wr_ready,

    output byte_t     rd_data,
    output logic      rd_last,
    output logic      rd_valid,
    input  wire logic rd_ready
);

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    // Each entry holds the last flag above the data byte
    logic [8:0] mem [DEPTH];

    // Extra top bit tells a full FIFO from an empty one
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0] fill;

    assign fill     = wr_ptr - rd_ptr;
    assign wr_ready = !fill[FIFO_ADDR_WIDTH];
    assign rd_valid = (fill != '0);

    assign {rd_last, rd_data} = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

    always_ff @(posedge clk_125mhz) begin
        if (wr_valid && wr_ready) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= {wr_last, wr_data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_valid && rd_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Fill level never goes past the depth, so a full FIFO took no write
    a_no_overflow: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        !(fill[FIFO_ADDR_WIDTH] && (fill[FIFO_ADDR_WIDTH-1:0] != '0))
    );

endmodule

`default_nettype wire

// ==== reply_frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reply_frame_builder
    import net_types_pkg::*;
    import echo_ctrl_pkg::*;
#(
    parameter mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_00,
    parameter ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter udp_port_t ECHO_PORT = 16'd1234
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,

    input  wire logic hdr_valid,
    output logic      hdr_ready,
    input  mac_addr_t hdr_dest_mac,
    input  ip_addr_t  hdr_dest_ip,
    input  udp_port_t hdr_dest_port,
    input  len16_t    hdr_udp_length,

    input  byte_t     rd_data,
    input  wire logic rd_last,
    input  wire logic rd_valid,
    output logic      rd_ready,

    output byte_t     tx_data,
    output logic      tx_valid,
    input  wire logic tx_ready,
    output logic      tx_last,

    output byte_t     led
);

    builder_state_t           state;
    hdr_index_t               hdr_idx;
    mac_addr_t                dest_mac;
    ip_addr_t                 dest_ip;
    udp_port_t                dest_port;
    len16_t                   udp_length;
    logic [15:0]              ip_csum;
    logic                     led_pending;
    len16_t                   total_len;
    len16_t                   total_len_in;
    logic [HDR_BYTES*8-1:0]   hdr_vec;

    // Ones' complement sum over the ten header words with the checksum word as zero
    function automatic logic [15:0] ip_header_checksum(input len16_t len, input ip_addr_t dst);
        logic [19:0] sum;
        sum = {4'd0, IP_VER_IHL, 8'h00}
            + {4'd0, len}
            + {4'd0, IP_TTL_REPLY, IP_PROTO_UDP}
            + {4'd0, LOCAL_IP[31:16]}
            + {4'd0, LOCAL_IP[15:0]}
            + {4'd0, dst[31:16]}
            + {4'd0, dst[15:0]};
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        return ~sum[15:0];
    endfunction

    assign total_len_in = hdr_udp_length + len16_t'(IP_HDR_BYTES);
    assign total_len    = udp_length + len16_t'(IP_HDR_BYTES);

    // Whole reply header with the first byte on the wire in the top bits
    // ID, flags and UDP checksum are zero
    assign hdr_vec = {
        dest_mac, LOCAL_MAC, ETH_TYPE_IPV4,
        IP_VER_IHL, 8'h00, total_len, 16'h0000, 16'h0000,
        IP_TTL_REPLY, IP_PROTO_UDP, ip_csum,
        LOCAL_IP, dest_ip,
        ECHO_PORT, dest_port, udp_length, 16'h0000
    };

    assign hdr_ready = (state == IDLE);
    assign rd_ready  = (state == SEND_PAYLOAD) && tx_ready;
    assign tx_valid  = (state == SEND_HDR) || ((state == SEND_PAYLOAD) && rd_valid);
    assign tx_last   = (state == SEND_PAYLOAD) && rd_valid && rd_last;

    always_comb begin
        if (state == SEND_PAYLOAD) begin
            tx_data = rd_data;
        end else begin
            tx_data = hdr_vec[8 * (HDR_BYTES - 1 - int'(hdr_idx)) +: 8];
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state       <= IDLE;
            hdr_idx     <= '0;
            led_pending <= 1'b0;
            led         <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_valid) begin
                        hdr_idx     <= '0;
                        led_pending <= 1'b1;
                        state       <= SEND_HDR;
                    end
                end
                SEND_HDR: begin
                    if (tx_ready) begin
                        if (hdr_idx == hdr_index_t'(HDR_BYTES - 1)) begin
                            hdr_idx <= '0;
                            state   <= SEND_PAYLOAD;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                SEND_PAYLOAD: begin
                    if (rd_valid && tx_ready) begin
                        // First payload byte of this reply goes to the LEDs
                        if (led_pending) begin
                            led         <= rd_data;
                            led_pending <= 1'b0;
                        end
                        if (rd_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Fields for the reply in flight
    always_ff @(posedge clk_125mhz) begin
        if (hdr_valid && hdr_ready) begin
            dest_mac   <= hdr_dest_mac;
            dest_ip    <= hdr_dest_ip;
            dest_port  <= hdr_dest_port;
            udp_length <= hdr_udp_length;
            ip_csum    <= ip_header_checksum(total_len_in, hdr_dest_ip);
        end
    end

    // A stalled byte waits unchanged, whether header or FIFO payload
    a_tx_stable: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last)
    );

endmodule

`default_nettype wire

// ==== udp_echo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core
    import net_types_pkg::*;
#(
    parameter mac_addr_t LOCAL_MAC       = 48'h02_00_00_00_00_00,
    parameter ip_addr_t  LOCAL_IP        = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter udp_port_t ECHO_PORT       = 16'd1234,
    parameter int        FIFO_ADDR_WIDTH = 13
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,

    // Request frames
    input  byte_t     rx_data,
    input  wire logic rx_valid,
    output logic      rx_ready,
    input  wire logic rx_last,

    // Reply frames
    output byte_t     tx_data,
    output logic      tx_valid,
    input  wire logic tx_ready,
    output logic      tx_last,

    output byte_t     led
);

    // Header hand-off
    logic      hdr_valid;
    logic      hdr_ready;
    mac_addr_t hdr_dest_mac;
    ip_addr_t  hdr_dest_ip;
    udp_port_t hdr_dest_port;
    len16_t    hdr_udp_length;

    // Payload into and out of the FIFO
    byte_t     wr_data;
    logic      wr_last;
    logic      wr_valid;
    logic      wr_ready;
    byte_t     rd_data;
    logic      rd_last;
    logic      rd_valid;
    logic      rd_ready;

    frame_header_parser #(
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) u_parser (
        .clk_125mhz     (clk_125mhz),
        .rst_125mhz     (rst_125mhz),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_last        (rx_last),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .hdr_dest_mac   (hdr_dest_mac),
        .hdr_dest_ip    (hdr_dest_ip),
        .hdr_dest_port  (hdr_dest_port),
        .hdr_udp_length (hdr_udp_length),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready)
    );

    payload_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_data    (wr_data),
        .wr_last    (wr_last),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .rd_data    (rd_data),
        .rd_last    (rd_last),
        .rd_valid   (rd_valid),
        .rd_ready   (rd_ready)
    );

    reply_frame_builder #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) u_builder (
        .clk_125mhz     (clk_125mhz),
        .rst_125mhz     (rst_125mhz),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .hdr_dest_mac   (hdr_dest_mac),
        .hdr_dest_ip    (hdr_dest_ip),
        .hdr_dest_port  (hdr_dest_port),
        .hdr_udp_length (hdr_udp_length),
        .rd_data        (rd_data),
        .rd_last        (rd_last),
        .rd_valid       (rd_valid),
        .rd_ready       (rd_ready),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_last        (tx_last),
        .led            (led)
    );

endmodule

`default_nettype wire

// ==== tb_frame_lib.svh ====
`ifndef TB_FRAME_LIB_SVH
`define TB_FRAME_LIB_SVH

`default_nettype none

typedef logic [7:0] byte_q_t[$];

// Responder identity matching the core defaults
localparam logic [47:0] RESP_MAC  = 48'h02_00_00_00_00_00;
localparam logic [31:0] RESP_IP   = {8'd192, 8'd168, 8'd1, 8'd128};
localparam logic [15:0] RESP_PORT = 16'd1234;

// 42 header bytes with the first byte on the wire in the top bits, then the payload
function automatic byte_q_t frame_from(input logic [335:0] hdr, input byte_q_t payload);
    byte_q_t q;
    for (int i = 41; i >= 0; i--) begin
        q.push_back(hdr[i*8 +: 8]);
    end
    foreach (payload[i]) begin
        q.push_back(payload[i]);
    end
    return q;
endfunction

// Ones' complement sum of the ten header words, folded and inverted
function automatic logic [15:0] ip_checksum(input logic [159:0] ip_hdr);
    logic [31:0] sum;
    sum = 32'd0;
    for (int i = 0; i < 10; i++) begin
        sum = sum + 32'(ip_hdr[i*16 +: 16]);
    end
    while (sum[31:16] != 16'd0) begin
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
endfunction

// Request with arbitrary TTL, ID and flags, checksums left at zero
function automatic byte_q_t build_request(
    input logic [47:0] dst_mac, input logic [47:0] src_mac, input logic [15:0] eth_type,
    input logic [31:0] src_ip, input logic [31:0] dst_ip,
    input logic [15:0] src_port, input logic [15:0] dst_port, input byte_q_t payload
);
    logic [335:0] hdr;
    logic [15:0]  udp_len;
    udp_len = 16'(payload.size() + 8);
    hdr = {dst_mac, src_mac, eth_type,
           8'h45, 8'h00, udp_len + 16'd20, 16'h1c46, 16'h4000,
           8'd32, 8'd17, 16'h0000, src_ip, dst_ip,
           src_port, dst_port, udp_len, 16'h0000};
    return frame_from(hdr, payload);
endfunction

// Reply with addresses and ports swapped, TTL 64, ID and flags zero, UDP checksum zero
function automatic byte_q_t build_reply(
    input logic [47:0] req_src_mac, input logic [31:0] req_src_ip,
    input logic [15:0] req_src_port, input byte_q_t payload
);
    logic [159:0] ip_hdr;
    logic [15:0]  udp_len;
    udp_len = 16'(payload.size() + 8);
    ip_hdr = {8'h45, 8'h00, udp_len + 16'd20, 16'h0000, 16'h0000,
              8'd64, 8'd17, 16'h0000, RESP_IP, req_src_ip};
    // Bytes 10 and 11 hold the checksum
    ip_hdr[79:64] = ip_checksum(ip_hdr);
    return frame_from({req_src_mac, RESP_MAC, 16'h0800, ip_hdr,
                       RESP_PORT, req_src_port, udp_len, 16'h0000}, payload);
endfunction

`default_nettype wire

`endif

// ==== tb_udp_echo.sv ====
`timescale 1ns/1ps
`include "tb_frame_lib.svh"
`default_nettype none

module tb_udp_echo;

    localparam int          TIMEOUT_CYCLES = 5000;
    localparam int          SILENCE_CYCLES = 200;
    localparam logic [47:0] CLIENT_MAC     = 48'h00_11_22_33_44_55;
    localparam logic [31:0] CLIENT_IP      = {8'd192, 8'd168, 8'd1, 8'd20};

    logic       clk_125mhz = 1'b0;
    logic       rst_125mhz;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;
    logic       rx_last;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_last;
    logic [7:0] led;

    integer seed;
    int     error_count;
    int     test_count;
    int     failed_tests;
    bit     bp_done;

    always #4 clk_125mhz = ~clk_125mhz;

    udp_echo_core DUT (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_last    (rx_last),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_last    (tx_last),
        .led        (led)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // One byte per accepted transfer with ready sampled on the falling edge
    task automatic send_frame(input byte_q_t f);
        int waited;
        @(posedge clk_125mhz);
        for (int i = 0; i < f.size(); i++) begin
            rx_data  <= f[i];
            rx_valid <= 1'b1;
            rx_last  <= (i == f.size() - 1);
            waited = 0;
            @(negedge clk_125mhz);
            while (!rx_ready && waited < TIMEOUT_CYCLES) begin
                @(negedge clk_125mhz);
                waited++;
            end
            if (!rx_ready) begin
                $display("Timeout at %0t ns: input never accepted byte %0d", $time, i);
                error_count++;
                @(posedge clk_125mhz);
                break;
            end
            @(posedge clk_125mhz);
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
    endtask

    task automatic collect_reply(output byte_q_t q);
        int idle;
        bit done;
        q    = {};
        idle = 0;
        done = 1'b0;
        while (!done && idle < TIMEOUT_CYCLES) begin
            @(negedge clk_125mhz);
            if (tx_valid && tx_ready) begin
                q.push_back(tx_data);
                done = tx_last;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (!done) begin
            $display("Timeout at %0t ns: reply stopped after %0d bytes", $time, q.size());
            error_count++;
        end
        // Let the final transfer edge go by
        @(posedge clk_125mhz);
    endtask

    task automatic expect_silence(input string name);
        for (int i = 0; i < SILENCE_CYCLES; i++) begin
            @(negedge clk_125mhz);
            if (tx_valid) begin
                $display("%s: unexpected reply output at %0t ns", name, $time);
                error_count++;
                break;
            end
        end
    endtask

    task automatic compare_reply(input string name, input byte_q_t got, input byte_q_t exp);
        check_value({name, " length"}, 64'(got.size()), 64'(exp.size()));
        for (int i = 0; i < got.size() && i < exp.size(); i++) begin
            check_value($sformatf("%s byte %0d", name, i), 64'(got[i]), 64'(exp[i]));
        end
    endtask

    task automatic make_payload(input int n, output byte_q_t p);
        p = {};
        for (int i = 0; i < n; i++) begin
            p.push_back(8'($random(seed)));
        end
    endtask

    // Send one matching request and compare the whole reply
    task automatic run_echo(input string name, input byte_q_t payload,
                            input logic [15:0] src_port);
        byte_q_t req;
        byte_q_t exp;
        byte_q_t got;
        req = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP,
                            src_port, RESP_PORT, payload);
        exp = build_reply(CLIENT_MAC, CLIENT_IP, src_port, payload);
        fork
            send_frame(req);
            collect_reply(got);
        join
        compare_reply(name, got, exp);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        @(negedge clk_125mhz);
        check_value("tx_valid", 64'(tx_valid), 64'd0);
        check_value("rx_ready", 64'(rx_ready), 64'd0);
        check_value("led", 64'(led), 64'd0);
        finish_test("reset_state", errs);
    endtask

    task automatic test_basic_echo();
        int      errs;
        byte_q_t payload;
        errs    = error_count;
        payload = {8'h48, 8'h65, 8'h6c, 8'h6c, 8'h6f, 8'h21};
        run_echo("basic reply", payload, 16'd40000);
        finish_test("basic_echo", errs);
    endtask

    task automatic test_filtering();
        int      errs;
        byte_q_t payload;
        byte_q_t req;
        byte_q_t short_req;
        errs    = error_count;
        payload = {8'h01, 8'h02, 8'h03, 8'h04};
        req = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP,
                            16'd5000, RESP_PORT + 16'd1, payload);
        send_frame(req);
        expect_silence("wrong port");
        req = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP ^ 32'd1,
                            16'd5000, RESP_PORT, payload);
        send_frame(req);
        expect_silence("wrong destination IP");
        req = build_request(RESP_MAC, CLIENT_MAC, 16'h86dd, CLIENT_IP, RESP_IP,
                            16'd5000, RESP_PORT, payload);
        send_frame(req);
        expect_silence("non-IPv4 ethertype");
        req = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP,
                            16'd5000, RESP_PORT, payload);
        for (int i = 0; i < 30; i++) begin
            short_req.push_back(req[i]);
        end
        send_frame(short_req);
        expect_silence("short frame");
        run_echo("reply after drops", payload, 16'd5001);
        finish_test("filtering", errs);
    endtask

    task automatic test_led();
        int      errs;
        byte_q_t payload;
        errs    = error_count;
        payload = {8'ha5, 8'h10, 8'h20};
        run_echo("first led reply", payload, 16'd6000);
        @(negedge clk_125mhz);
        check_value("led", 64'(led), 64'(payload[0]));
        payload = {8'h3c};
        run_echo("second led reply", payload, 16'd6001);
        @(negedge clk_125mhz);
        check_value("led", 64'(led), 64'(payload[0]));
        finish_test("led", errs);
    endtask

    task automatic test_back_pressure();
        int      errs;
        int      n;
        byte_q_t pay_a;
        byte_q_t pay_b;
        byte_q_t req_a;
        byte_q_t req_b;
        byte_q_t got_a;
        byte_q_t got_b;
        errs = error_count;
        make_payload(1 + int'($unsigned($random(seed)) % 40), pay_a);
        make_payload(1 + int'($unsigned($random(seed)) % 40), pay_b);
        req_a = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP,
                              16'd7000, RESP_PORT, pay_a);
        req_b = build_request(RESP_MAC, CLIENT_MAC, 16'h0800, CLIENT_IP, RESP_IP,
                              16'd7001, RESP_PORT, pay_b);
        bp_done = 1'b0;
        fork
            begin
                send_frame(req_a);
                send_frame(req_b);
            end
            begin
                collect_reply(got_a);
                collect_reply(got_b);
                bp_done = 1'b1;
            end
            begin
                n = 0;
                while (!bp_done && n < 4 * TIMEOUT_CYCLES) begin
                    @(posedge clk_125mhz);
                    tx_ready <= 1'($random(seed));
                    n++;
                end
            end
        join
        tx_ready <= 1'b1;
        compare_reply("first stalled reply", got_a,
                      build_reply(CLIENT_MAC, CLIENT_IP, 16'd7000, pay_a));
        compare_reply("second stalled reply", got_b,
                      build_reply(CLIENT_MAC, CLIENT_IP, 16'd7001, pay_b));
        finish_test("back_pressure", errs);
    endtask

    initial begin
        rst_125mhz   = 1'b1;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        tx_ready     = 1'b1;
        seed         = 32'haffb;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        bp_done      = 1'b0;
        repeat (8) @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;

        test_reset_state();
        test_basic_echo();
        test_filtering();
        test_led();
        test_back_pressure();

        $display("Summary: %0d tests run, %0d failing, %0d check errors",
                 test_count, failed_tests, error_count);
        if (failed_tests == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
net_types_pkg.sv
echo_ctrl_pkg.sv
frame_header_parser.sv
payload_fifo.sv
reply_frame_builder.sv
udp_echo_core.sv
tb_udp_echo.sv

// ==== Makefile ====
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Mdir $(OBJ_DIR)
TOP       ?= tb_udp_echo
FILELIST  ?= sim.f
LOG       ?= sim.log
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
